// ==== common/cpuPkg.sv ====
// cpu package: control word and data memory request shared by the datapath blocks
`default_nettype none

package cpuPkg;

    import isaPkg::*;

    // one set per instruction, all zero is a no-op
    typedef struct packed {
        logic  regDst;    // 1 = rd, 0 = rt
        logic  aluSrc;    // 1 = immediate as operand b
        logic  memToReg;  // 1 = load data to register
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  branch;    // beq
        logic  jump;      // j
        aluOpT aluOp;
    } ctrlT;

    // request half of the data port, read data comes back on its own
    typedef struct packed {
        logic        write;  // single cycle store strobe
        logic [31:0] addr;   // byte address, word aligned
        logic [31:0] wdata;
    } dmemReqT;

endpackage

`default_nettype wire

// ==== common/isaPkg.sv ====
// isa package: MIPS32 subset opcodes, funct codes, instruction views and alu ops
`default_nettype none

package isaPkg;

    typedef enum logic [5:0] {
        opRType = 6'h00,  // funct selects the operation
        opJ     = 6'h02,
        opBeq   = 6'h04,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeT;

    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } functT;

    typedef struct packed {
        opcodeT     opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;  // not used by this subset
        functT      funct;
    } rTypeT;

    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;  // signed offset or operand
    } iTypeT;

    typedef struct packed {
        opcodeT      opcode;
        logic [25:0] target26;  // word index within the 256MB region
    } jTypeT;

    // one 32-bit word, three ways to look at it
    typedef union packed {
        rTypeT r;
        iTypeT i;
        jTypeT j;
    } instrT;

    typedef enum logic [3:0] {
        aluAnd = 4'b0000,
        aluOr  = 4'b0001,
        aluAdd = 4'b0010,
        aluSub = 4'b0110,
        aluSlt = 4'b0111
    } aluOpT;

endpackage

`default_nettype wire

// ==== rtl/alu.sv ====
// alu: 32-bit and, or, add, sub and signed slt with a zero flag
`default_nettype none

module alu
    import isaPkg::*;
(
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  aluOpT       op,
    output logic [31:0] result,
    output logic        zero
);

    logic lessThan;  // signed compare, free of subtract overflow

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            aluAnd: begin
                result = a & b;
            end
            aluOr: begin
                result = a | b;
            end
            aluAdd: begin
                result = a + b;  // wraps, no overflow trap
            end
            aluSub: begin
                result = a - b;
            end
            aluSlt: begin
                result = {31'd0, lessThan};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == 32'd0);  // beq taken when set

endmodule

`default_nettype wire

// ==== rtl/cpuTop.sv ====
// cpu top: single cycle MIPS32 subset core with instruction and data ports
`default_nettype none

module cpuTop
    import isaPkg::*;
    import cpuPkg::*;
#(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] instrAddr,  // current pc
    input  logic [31:0] instrData,  // valid in the same cycle
    output dmemReqT     dmemReq,
    input  logic [31:0] dmemRdata   // word at dmemReq.addr
);

    instrT       instr;
    ctrlT        ctrl;
    logic [31:0] imm;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic [31:0] wbData;
    logic [4:0]  wrReg;
    logic        regWe;
    logic        zero;

    assign instr = instrData;

    fetchUnit #(
        .resetPc(resetPc)
    ) fetch (
        .clk   (clk),
        .rst   (rst),
        .branch(ctrl.branch),
        .jump  (ctrl.jump),
        .zero  (zero),
        .imm   (imm),
        .target(instr.j.target26),
        .pc    (instrAddr)
    );

    instrDecoder decoder (
        .instr(instr),
        .ctrl (ctrl),
        .imm  (imm)
    );

    assign wrReg  = ctrl.regDst ? instr.r.rd : instr.r.rt;   // R-type writes rd
    assign regWe  = ctrl.regWrite & ~rst;                    // nothing retires in reset
    assign wbData = ctrl.memToReg ? dmemRdata : aluResult;   // lw vs alu result

    regFile regs (
        .clk    (clk),
        .rdAddrA(instr.r.rs),
        .rdAddrB(instr.r.rt),
        .wrAddr (wrReg),
        .wrEn   (regWe),
        .wrData (wbData),
        .rdDataA(rsData),
        .rdDataB(rtData)
    );

    assign aluB = ctrl.aluSrc ? imm : rtData;  // immediate for addi, lw, sw

    alu mainAlu (
        .a     (rsData),
        .b     (aluB),
        .op    (ctrl.aluOp),
        .result(aluResult),
        .zero  (zero)
    );

    // store strobe lasts the sw cycle only
    assign dmemReq.write = ctrl.memWrite & ~rst;
    assign dmemReq.addr  = aluResult;  // also the load address
    assign dmemReq.wdata = rtData;

endmodule

`default_nettype wire

// ==== rtl/fetchUnit.sv ====
// fetch unit: program counter register and next pc selection
`default_nettype none

module fetchUnit #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        branch,  // beq in this cycle
    input  logic        jump,    // j in this cycle
    input  logic        zero,    // operands equal
    input  logic [31:0] imm,     // sign extended offset
    input  logic [25:0] target,
    output logic [31:0] pc
);

    logic [31:0] pcPlus4;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [31:0] nextPc;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {imm[29:0], 2'b00};  // word offset
    assign jumpTarget   = {pcPlus4[31:28], target, 2'b00};  // keep region bits

    // jump wins over a taken branch
    always_comb begin
        if (jump) begin
            nextPc = jumpTarget;
        end else if (branch && zero) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetPc;
        end else begin
            pc <= nextPc;  // one instruction per cycle
        end
    end

endmodule

`default_nettype wire

// ==== rtl/instrDecoder.sv ====
// instruction decoder: main control, alu control and immediate sign extension
`default_nettype none

module instrDecoder
    import isaPkg::*;
    import cpuPkg::*;
(
    input  instrT       instr,
    output ctrlT        ctrl,
    output logic [31:0] imm
);

    aluOpT functOp;  // alu op as R-type funct asks for it

    always_comb begin
        case (instr.r.funct)
            fnAdd:   functOp = aluAdd;
            fnSub:   functOp = aluSub;
            fnAnd:   functOp = aluAnd;
            fnOr:    functOp = aluOr;
            fnSlt:   functOp = aluSlt;
            default: functOp = aluAdd;  // unsupported funct falls back to add
        endcase
    end

    always_comb begin
        ctrl       = '0;      // unknown opcode stays a no-op
        ctrl.aluOp = aluAdd;
        case (instr.r.opcode)
            opRType: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = functOp;
            end
            opAddi: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opLw: begin
                ctrl.aluSrc   = 1'b1;  // base + offset
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
            end
            opSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            opBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub;  // zero flag means equal
            end
            opJ: begin
                ctrl.jump = 1'b1;
            end
            default: ;
        endcase
    end

    assign imm = {{16{instr.i.imm16[15]}}, instr.i.imm16};  // sign extend

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
// register file: 32 x 32 bits, two combinational reads, one clocked write
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic [4:0]  rdAddrA,
    input  logic [4:0]  rdAddrB,
    input  logic [4:0]  wrAddr,
    input  logic        wrEn,
    input  logic [31:0] wrData,
    output logic [31:0] rdDataA,
    output logic [31:0] rdDataB
);

    logic [31:0] regs [32];  // entry zero is never written

    always_ff @(posedge clk) begin
        if (wrEn && (wrAddr != 5'd0)) begin
            regs[wrAddr] <= wrData;  // visible from the next cycle
        end
    end

    // same-cycle read of a register being written sees the old value
    always_comb begin
        if (rdAddrA == 5'd0) begin
            rdDataA = '0;  // $zero
        end else begin
            rdDataA = regs[rdAddrA];
        end
    end

    always_comb begin
        if (rdAddrB == 5'd0) begin
            rdDataB = '0;
        end else begin
            rdDataB = regs[rdAddrB];
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
common/isaPkg.sv
common/cpuPkg.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/alu.sv
rtl/fetchUnit.sv
rtl/cpuTop.sv
test/cpuTb.sv

// ==== test/cpuTb.sv ====
// cpu testbench: runs the program from the tests file and checks every store the core makes
`default_nettype none

module cpuTb
    import isaPkg::*;
    import cpuPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int numRecs    = 128;
    localparam int cycleLimit = 2000;  // program is far shorter
    localparam int resetTest  = 1;
    localparam int jumpTest   = 6;     // also finishes on reaching the end

    logic        clk;
    logic        rst;
    logic [31:0] instrAddr;
    logic [31:0] instrData;
    dmemReqT     dmemReq;
    logic [31:0] dmemRdata;

    logic [71:0] recs [numRecs];  // kind, test, addr, data
    logic [31:0] imem [256];
    logic [31:0] dmem [1024];
    logic [31:0] resetWord;       // a store from the program, fetched while rst is high

    logic [31:0] expAddr [$];  // expected stores in program order
    logic [31:0] expData [$];
    int          expTest [$];
    int          remaining [7];  // stores still due per test
    int          testErrs [7];
    int          passCount;
    int          failCount;
    int          strayStores;
    int          storeIndex;
    logic [31:0] endAddr;        // address of the final self-jump

    cpuTop #(
        .resetPc(32'h0000_0000)
    ) uut (
        .clk      (clk),
        .rst      (rst),
        .instrAddr(instrAddr),
        .instrData(instrData),
        .dmemReq  (dmemReq),
        .dmemRdata(dmemRdata)
    );

    // both memories answer within the cycle
    assign instrData = rst ? resetWord : imem[instrAddr[9:2]];
    assign dmemRdata = dmem[dmemReq.addr[11:2]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    function automatic string testName(input int id);
        case (id)
            1:       return "reset";
            2:       return "arithmetic";
            3:       return "immediate arithmetic";
            4:       return "memory round trip";
            5:       return "branches";
            6:       return "jump";
            default: return "unknown";
        endcase
    endfunction

    task automatic reportTest(input int id);
        if (testErrs[id] == 0) begin
            $display("test %0d %s: ok", id, testName(id));
            passCount++;
        end else begin
            $display("test %0d %s: %0d error(s)", id, testName(id), testErrs[id]);
            failCount++;
        end
    endtask

    // program words into imem, expected stores into the queues
    task automatic loadTests();
        logic [71:0] rec;
        logic [31:0] addr;
        int          id;
        int          i;
        for (i = 0; i < 256; i++) begin
            imem[i] = '0;  // sll $0 acts as a no-op
        end
        for (i = 0; i < 1024; i++) begin
            dmem[i] = '0;
        end
        for (i = 0; i < numRecs; i++) begin
            recs[i] = '0;  // kind 0 marks an unused slot
        end
        endAddr   = 32'hffff_fffc;
        resetWord = '0;
        $readmemh("test/cpuTests.mem", recs);
        for (i = 0; i < numRecs; i++) begin
            rec  = recs[i];
            id   = int'(rec[67:64]);
            addr = rec[63:32];
            case (rec[71:68])
                4'h1: begin
                    imem[addr[9:2]] = rec[31:0];
                    if (resetWord == '0 && rec[31:26] == opSw) begin
                        resetWord = rec[31:0];  // first sw of the program
                    end
                end
                4'h2: begin
                    expAddr.push_back(addr);
                    expData.push_back(rec[31:0]);
                    expTest.push_back(id);
                    remaining[id]++;
                end
                4'h3: endAddr = addr;
                default: ;
            endcase
        end
    endtask

    task automatic checkReset(input string phase);
        if (instrAddr !== 32'h0 || dmemReq.write !== 1'b0) begin
            $display("Fail at %0d ns: %s, instrAddr %h write %b, expected instrAddr 0 write 0",
                     $time, phase, instrAddr, dmemReq.write);
            testErrs[resetTest]++;
        end
    endtask

    task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] wantAddr;
        logic [31:0] wantData;
        int          id;
        if (expAddr.size() == 0) begin
            $display("a store of %h to %h at %0d ns came after all recorded stores",
                     data, addr, $time);
            strayStores++;
        end else begin
            wantAddr = expAddr.pop_front();
            wantData = expData.pop_front();
            id       = expTest.pop_front();
            storeIndex++;
            if (addr !== wantAddr || data !== wantData) begin
                $display("Fail at %0d ns: store %0d expected [%h] = %h, got [%h] = %h",
                         $time, storeIndex, wantAddr, wantData, addr, data);
                testErrs[id]++;
            end
            remaining[id]--;
            if (remaining[id] == 0 && id != jumpTest) begin
                reportTest(id);
            end
        end
    endtask

    // pre-edge values, the pc moves in the nba region
    always @(posedge clk) begin
        if (dmemReq.write === 1'b1) begin
            dmem[dmemReq.addr[11:2]] <= dmemReq.wdata;
            checkStore(dmemReq.addr, dmemReq.wdata);
        end
    end

    initial begin
        int cycles;
        int id;
        rst         = 1'b1;
        passCount   = 0;
        failCount   = 0;
        strayStores = 0;
        storeIndex  = 0;
        for (id = 0; id < 7; id++) begin
            remaining[id] = 0;
            testErrs[id]  = 0;
        end
        loadTests();

        repeat (9) begin
            @(negedge clk);
            checkReset("while rst is high");
        end
        @(posedge clk);  // tenth edge in reset
        #1 rst = 1'b0;
        @(negedge clk);
        checkReset("first cycle after reset");
        reportTest(resetTest);

        cycles = 0;
        while (instrAddr !== endAddr && cycles < cycleLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (instrAddr !== endAddr) begin
            $display("timed out: instrAddr never reached the final jump at %h within %0d cycles",
                     endAddr, cycleLimit);
            testErrs[jumpTest]++;
        end

        // tests whose stores never showed up
        for (id = 2; id <= jumpTest; id++) begin
            if (remaining[id] > 0) begin
                $display("test %0d %s is missing %0d of its expected stores",
                         id, testName(id), remaining[id]);
                testErrs[id]++;
                if (id != jumpTest) begin
                    reportTest(id);
                end
            end
        end
        reportTest(jumpTest);

        $display("tests passed: %0d, failed: %0d, stray stores: %0d",
                 passCount, failCount, strayStores);
        if (failCount == 0 && strayStores == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/cpuTests.mem ====
// columns kind_test_addr_data, kind 1 program word, 2 expected store, 3 end marker
// test 2 arithmetic, 3 immediate, 4 memory round trip, 5 branches, 6 jump
1_2_00000000_20010005 // addi $1, $0, 5
1_2_00000004_2002FFFD // addi $2, $0, -3
1_2_00000008_00221820 // add $3, $1, $2
1_2_0000000C_00222022 // sub $4, $1, $2
1_2_00000010_00222824 // and $5, $1, $2
1_2_00000014_00223025 // or $6, $1, $2
1_2_00000018_0041382A // slt $7, $2, $1
1_2_0000001C_00210020 // add $0, $1, $1
1_2_00000020_AC030100 // sw $3, 0x100($0)
1_2_00000024_AC040104 // sw $4, 0x104($0)
1_2_00000028_AC050108 // sw $5, 0x108($0)
1_2_0000002C_AC06010C // sw $6, 0x10c($0)
1_2_00000030_AC070110 // sw $7, 0x110($0)
1_2_00000034_AC000114 // sw $0, 0x114($0)
1_3_00000038_2029FFF9 // addi $9, $1, -7
1_3_0000003C_AC090118 // sw $9, 0x118($0)
1_4_00000040_200A1234 // addi $10, $0, 0x1234
1_4_00000044_AC0A011C // sw $10, 0x11c($0)
1_4_00000048_8C0B011C // lw $11, 0x11c($0)
1_4_0000004C_216C0001 // addi $12, $11, 1
1_4_00000050_AC0C0120 // sw $12, 0x120($0)
1_5_00000054_10210001 // beq $1, $1, +1 taken
1_5_00000058_AC010200 // sw $1, 0x200($0) skipped
1_5_0000005C_AC040204 // sw $4, 0x204($0)
1_5_00000060_10220001 // beq $1, $2, +1 not taken
1_5_00000064_AC070208 // sw $7, 0x208($0)
1_5_00000068_AC04020C // sw $4, 0x20c($0)
1_6_0000006C_0800001D // j 0x74
1_6_00000070_AC010210 // sw $1, 0x210($0) skipped
1_6_00000074_AC030214 // sw $3, 0x214($0)
1_6_00000078_0800001E // j 0x78 self-jump
2_2_00000100_00000002 // add
2_2_00000104_00000008 // sub
2_2_00000108_00000005 // and
2_2_0000010C_FFFFFFFD // or
2_2_00000110_00000001 // slt with negative rs
2_2_00000114_00000000 // $0 unchanged
2_3_00000118_FFFFFFFE // 5 + -7
2_4_0000011C_00001234
2_4_00000120_00001235 // loaded word plus one
2_5_00000204_00000008 // taken path marker
2_5_00000208_00000001 // fall-through marker
2_5_0000020C_00000008 // not-taken target marker
2_6_00000214_00000002 // jump landing marker
3_6_00000078_00000000
